/* files.f */
+incdir+include
source/videoTimingPkg.sv
source/tilePkg.sv
source/videoTiming.sv
source/cpuInterface.sv
source/tileFetch.sv
source/pixelSelect.sv
source/colorOutput.sv
source/tileLayerGen.sv
verification/tileLayerGenTb.sv

/* include/tileGen_macros.svh */
//**************************************************
// Raster timing and pixel pipeline constants for
// the tile layer generator
//**************************************************

`ifndef TILEGEN_MACROS_SVH
`define TILEGEN_MACROS_SVH

// Horizontal raster, in pixels
`define H_TOTAL       384   // Pixels per line
`define H_VISIBLE     320   // Active pixels
`define H_SYNC_START  336   // First NHSY low pixel
`define H_SYNC_END    368   // First pixel after sync

// Vertical raster, in lines
`define V_TOTAL       264   // Lines per frame
`define V_VISIBLE     240   // Active lines
`define V_SYNC_START  248   // First NVSY low line
`define V_SYNC_END    252   // First line after sync

// Pixel pipeline
`define PIXEL_DIV     4     // M24 cycles per pixel
`define PIXEL_LATENCY 2     // Pixels from hCount to output pins
`define TILE_WIDTH    8     // Pixels per tile row

`endif

/* source/colorOutput.sv */
//**************************************************
// Color output: 12-bit layer color and opaque flag
//**************************************************

`default_nettype none

module colorOutput (
    input  wire                  M24,
    input  wire                  rstN,
    input  wire                  pixelEn,
    input  wire  tilePkg::colorIndex_t pixel,
    input  wire  tilePkg::colorAttr_t  attr,
    output tilePkg::colorOut_t   color,
    output logic                 opaque
);

    // Bits 11:8 from COL 3:0, bits 7:4 from COL 7:4, pixel below
    always_ff @(posedge M24 or negedge rstN) begin
        if (!rstN) begin
            color  <= '0;
            opaque <= 1'b0;
        end else if (pixelEn) begin
            color  <= {attr[3:0], attr[7:4], pixel};
            opaque <= |pixel;     // Pen 0 is transparent
        end
    end

endmodule

`default_nettype wire

/* source/cpuInterface.sv */
//**************************************************
// CPU port: flip control register and ROM byte
// readback
//**************************************************

`default_nettype none

module cpuInterface (
    input  wire                 M24,
    input  wire                 rstN,
    input  wire  [1:0]          busAddr,
    input  wire                 busRead,
    input  wire                 busWrite,
    input  wire  [7:0]          busDataIn,
    input  wire  tilePkg::tileWord_t vc,
    output logic [7:0]          busDataOut,
    output logic                busOutEn,
    output logic                flipAll,
    output logic                flipAttrEn
);

    // Control bits and read strobe
    always_ff @(posedge M24 or negedge rstN) begin
        if (!rstN) begin
            flipAll    <= 1'b0;
            flipAttrEn <= 1'b0;
            busOutEn   <= 1'b0;
        end else begin
            busOutEn <= busRead;             // Data valid one cycle after read
            if (busWrite) begin
                flipAll    <= busDataIn[0];  // Flip every tile
                flipAttrEn <= busDataIn[1];  // Honour COL bit 0
            end
        end
    end

    // Plane byte picked by address
    always_ff @(posedge M24) begin
        if (busRead) begin
            busDataOut <= vc[busAddr];
        end
    end

endmodule

`default_nettype wire

/* source/pixelSelect.sv */
//**************************************************
// Pixel select: one bit from each plane at the
// (optionally mirrored) column
//**************************************************

`default_nettype none

module pixelSelect (
    input  wire                  M24,
    input  wire                  rstN,
    input  wire                  pixelEn,
    input  wire  tilePkg::pixelIndex_t position,
    input  wire  tilePkg::tileWord_t   tile,
    input  wire  tilePkg::colorAttr_t  attr,
    input  wire                  flip,
    output tilePkg::colorIndex_t pixel,
    output tilePkg::colorAttr_t  attrOut
);
    import tilePkg::*;

    pixelIndex_t bitIndex;
    colorIndex_t planeBits;

    assign bitIndex = flip ? ~position : position;  // Mirror is 7 - n

    // Planar decode, plane p gives pixel bit p
    always_comb begin
        for (int p = 0; p < $bits(colorIndex_t); p++) begin
            planeBits[p] = tile[p][bitIndex];
        end
    end

    always_ff @(posedge M24 or negedge rstN) begin
        if (!rstN) begin
            pixel   <= '0;
            attrOut <= '0;
        end else if (pixelEn) begin
            pixel   <= planeBits;
            attrOut <= attr;      // Attribute travels with its pixel
        end
    end

endmodule

`default_nettype wire

/* source/tileFetch.sv */
//**************************************************
// Tile fetch: ROM word and attribute capture,
// flip resolution per tile
//**************************************************

`default_nettype none

module tileFetch (
    input  wire                  M24,
    input  wire                  rstN,
    input  wire                  tileLoad,
    input  wire  tilePkg::tileWord_t  vc,
    input  wire  tilePkg::colorAttr_t col,
    input  wire                  flipAll,
    input  wire                  flipAttrEn,
    output tilePkg::tileWord_t   tile,
    output tilePkg::colorAttr_t  attr,
    output logic                 flip
);

    logic tileFlip;

    // Global flip, inverted again by the tile's own request
    assign tileFlip = flipAll ^ (flipAttrEn & col[0]);

    always_ff @(posedge M24 or negedge rstN) begin
        if (!rstN) begin
            tile <= '0;           // Transparent until first fetch
            attr <= '0;
            flip <= 1'b0;
        end else if (tileLoad) begin
            tile <= vc;           // Next tile's planes
            attr <= col;
            flip <= tileFlip;     // Held for the whole tile
        end
    end

endmodule

`default_nettype wire

/* source/tileLayerGen.sv */
//**************************************************
// Tile layer generator top: timing, CPU port,
// layer A and fix layer pixel chains
//**************************************************

`default_nettype none

module tileLayerGen (
    input  wire                  M24,
    input  wire                  rstN,
    input  wire  tilePkg::tileWord_t   VC,
    input  wire  tilePkg::colorAttr_t  COL,
    input  wire  tilePkg::pixelIndex_t zaH,
    input  wire  [1:0]           busAddr,
    input  wire                  busRead,
    input  wire                  busWrite,
    input  wire  [7:0]           busDataIn,
    output tilePkg::colorOut_t   DSA,
    output logic [7:0]           DFI,
    output logic                 NSAC,
    output logic                 NFIC,
    output logic                 NHBK,
    output logic                 NVBK,
    output logic                 NHSY,
    output logic                 NVSY,
    output logic                 NCSY,
    output logic                 M12,
    output logic                 M6,
    output logic                 P1H,
    output logic [7:0]           busDataOut,
    output logic                 busOutEn
);
    import tilePkg::*;

    logic        pixelEn;
    logic        tileLoad;
    pixelIndex_t hPixel;         // Fix layer column
    logic        flipAll;
    logic        flipAttrEn;
    tileWord_t   layerATile;
    tileWord_t   fixTile;
    colorAttr_t  layerAAttr;
    colorAttr_t  fixAttr;
    logic        layerAFlip;
    logic        fixFlip;
    colorIndex_t layerAPixel;
    colorIndex_t fixPixel;
    colorAttr_t  layerAPixAttr;
    colorAttr_t  fixPixAttr;
    colorOut_t   fixColor;

    videoTiming i_videoTiming (
        .M24(M24), .rstN(rstN), .pixelEn(pixelEn), .tileLoad(tileLoad), .hPixel(hPixel),
        .NHBK(NHBK), .NVBK(NVBK), .NHSY(NHSY), .NVSY(NVSY), .NCSY(NCSY),
        .M12(M12), .M6(M6), .P1H(P1H)
    );

    cpuInterface i_cpuInterface (
        .M24(M24), .rstN(rstN), .busAddr(busAddr), .busRead(busRead), .busWrite(busWrite),
        .busDataIn(busDataIn), .vc(VC), .busDataOut(busDataOut), .busOutEn(busOutEn),
        .flipAll(flipAll), .flipAttrEn(flipAttrEn)
    );

    // Layer A, column from external scroll
    tileFetch i_layerAFetch (
        .M24(M24), .rstN(rstN), .tileLoad(tileLoad), .vc(VC), .col(COL),
        .flipAll(flipAll), .flipAttrEn(flipAttrEn),
        .tile(layerATile), .attr(layerAAttr), .flip(layerAFlip)
    );

    pixelSelect i_layerASelect (
        .M24(M24), .rstN(rstN), .pixelEn(pixelEn), .position(zaH), .tile(layerATile),
        .attr(layerAAttr), .flip(layerAFlip), .pixel(layerAPixel), .attrOut(layerAPixAttr)
    );

    colorOutput i_layerAColor (
        .M24(M24), .rstN(rstN), .pixelEn(pixelEn), .pixel(layerAPixel),
        .attr(layerAPixAttr), .color(DSA), .opaque(NSAC)
    );

    // Fix layer, column from the raster counter
    tileFetch i_fixFetch (
        .M24(M24), .rstN(rstN), .tileLoad(tileLoad), .vc(VC), .col(COL),
        .flipAll(flipAll), .flipAttrEn(flipAttrEn),
        .tile(fixTile), .attr(fixAttr), .flip(fixFlip)
    );

    pixelSelect i_fixSelect (
        .M24(M24), .rstN(rstN), .pixelEn(pixelEn), .position(hPixel), .tile(fixTile),
        .attr(fixAttr), .flip(fixFlip), .pixel(fixPixel), .attrOut(fixPixAttr)
    );

    colorOutput i_fixColor (
        .M24(M24), .rstN(rstN), .pixelEn(pixelEn), .pixel(fixPixel),
        .attr(fixPixAttr), .color(fixColor), .opaque(NFIC)
    );

    assign DFI = fixColor[7:0];  // Fix layer has no upper palette bits

endmodule

`default_nettype wire

/* source/tilePkg.sv */
//**************************************************
// Tile data types: ROM word, attribute, pixel
// index and color words
//**************************************************

`default_nettype none

package tilePkg;

    // Four bit-plane bytes, plane p in bits 8p+7:8p, bit n is pixel n
    typedef logic [3:0][7:0] tileWord_t;

    typedef logic [7:0] colorAttr_t;   // COL, bit 0 requests flip
    typedef logic [2:0] pixelIndex_t;  // Column inside a tile
    typedef logic [3:0] colorIndex_t;  // One bit per plane
    typedef logic [11:0] colorOut_t;   // Layer color word to the mixer

endpackage

`default_nettype wire

/* source/videoTiming.sv */
//**************************************************
// Video timing: M12/M6 dividers, pixel strobe,
// raster counters, blanking and sync outputs
//**************************************************

`default_nettype none
`include "tileGen_macros.svh"

module videoTiming (
    input  wire                  M24,
    input  wire                  rstN,
    output logic                 pixelEn,
    output logic                 tileLoad,
    output tilePkg::pixelIndex_t hPixel,
    output logic                 NHBK,
    output logic                 NVBK,
    output logic                 NHSY,
    output logic                 NVSY,
    output logic                 NCSY,
    output logic                 M12,
    output logic                 M6,
    output logic                 P1H
);
    import videoTimingPkg::*;

    localparam int DivWidth = $clog2(`PIXEL_DIV);
    localparam logic [3:0] FlagsReset = 4'b0011;  // Blanked, no sync

    logic [DivWidth-1:0] divCnt;                  // M24 phase inside a pixel
    hCount_t             hCount;
    vCount_t             vCount;
    logic                hVisible;
    logic                vVisible;
    logic                hSyncN;
    logic                vSyncN;
    logic [3:0]          flagPipe [`PIXEL_LATENCY];  // {hVis, vVis, hSyncN, vSyncN}

    always_ff @(posedge M24 or negedge rstN) begin
        if (!rstN) begin
            divCnt <= '0;
        end else begin
            divCnt <= divCnt + 1'b1;
        end
    end

    assign M12     = divCnt[0];             // Half of M24
    assign M6      = divCnt[DivWidth-1];    // Quarter of M24
    assign pixelEn = (divCnt == DivWidth'(`PIXEL_DIV / 2));  // Cycle right after M6 rise

    always_ff @(posedge M24 or negedge rstN) begin
        if (!rstN) begin
            hCount <= '0;
            vCount <= '0;
        end else if (pixelEn) begin
            if (hCount == hCount_t'(`H_TOTAL - 1)) begin
                hCount <= '0;
                if (vCount == vCount_t'(`V_TOTAL - 1)) begin
                    vCount <= '0;  // New frame
                end else begin
                    vCount <= vCount + 1'b1;
                end
            end else begin
                hCount <= hCount + 1'b1;
            end
        end
    end

    assign hPixel   = hCount[2:0];
    assign tileLoad = pixelEn && (hCount[2:0] == 3'(`TILE_WIDTH - 1));  // Last column of tile
    assign P1H      = hCount[0];

    // Raw raster flags for the current hCount
    assign hVisible = (hCount < hCount_t'(`H_VISIBLE));
    assign vVisible = (vCount < vCount_t'(`V_VISIBLE));
    assign hSyncN   = !((hCount >= hCount_t'(`H_SYNC_START)) && (hCount < hCount_t'(`H_SYNC_END)));
    assign vSyncN   = !((vCount >= vCount_t'(`V_SYNC_START)) && (vCount < vCount_t'(`V_SYNC_END)));

    // Delay flags to line up with the pixel pipeline
    always_ff @(posedge M24 or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `PIXEL_LATENCY; i++) begin
                flagPipe[i] <= FlagsReset;
            end
        end else if (pixelEn) begin
            flagPipe[0] <= {hVisible, vVisible, hSyncN, vSyncN};
            for (int i = 1; i < `PIXEL_LATENCY; i++) begin
                flagPipe[i] <= flagPipe[i-1];
            end
        end
    end

    assign NHBK = flagPipe[`PIXEL_LATENCY-1][3];
    assign NVBK = flagPipe[`PIXEL_LATENCY-1][2];
    assign NHSY = flagPipe[`PIXEL_LATENCY-1][1];
    assign NVSY = flagPipe[`PIXEL_LATENCY-1][0];
    assign NCSY = NHSY & NVSY;  // Composite sync, low if either is low

endmodule

`default_nettype wire

/* source/videoTimingPkg.sv */
//**************************************************
// Raster counter types
//**************************************************

`default_nettype none

package videoTimingPkg;

    // Pixel position within a line, 0 to 383
    typedef logic [8:0] hCount_t;

    // Line number within a frame, 0 to 263
    typedef logic [8:0] vCount_t;

endpackage

`default_nettype wire

/* verification/tileLayerGenTb.sv */
//**************************************************
// Testbench for the tile layer generator: raster
// timing, CPU readback, flip control, pixel model
//**************************************************

`default_nettype none
`include "tileGen_macros.svh"

module tileLayerGenTb;

    localparam int LineCycles = `H_TOTAL * `PIXEL_DIV;  // M24 cycles per line
    localparam int MaxLines   = 600;

    logic M24, rstN, busRead, busWrite;
    logic [31:0] VC;
    logic [7:0] COL, busDataIn;
    logic [2:0] zaH;
    logic [1:0] busAddr;
    wire [11:0] DSA;
    wire [7:0] DFI, busDataOut;
    wire NSAC, NFIC, NHBK, NVBK, NHSY, NVSY, NCSY, M12, M6, P1H, busOutEn;

    integer seed;
    integer rnd;
    int k, hRises, visRises, hFalls, vFalls, lineNo, pixelChecks, vLine;
    logic armed, seenHFall, seenVFall, prevNhsy, prevNvsy, lastM12, m12Valid;
    logic [31:0] expVc;  // Stimulus the next visible line was built from
    logic [7:0] expCol;
    logic [2:0] expZa;
    logic expFlipAll, expFlipAttrEn;

    tileLayerGen i_dut (
        .M24(M24), .rstN(rstN), .VC(VC), .COL(COL), .zaH(zaH), .busAddr(busAddr),
        .busRead(busRead), .busWrite(busWrite), .busDataIn(busDataIn),
        .DSA(DSA), .DFI(DFI), .NSAC(NSAC), .NFIC(NFIC), .NHBK(NHBK), .NVBK(NVBK),
        .NHSY(NHSY), .NVSY(NVSY), .NCSY(NCSY), .M12(M12), .M6(M6), .P1H(P1H),
        .busDataOut(busDataOut), .busOutEn(busOutEn)
    );

    initial begin
        M24 = 1'b0;
        forever #10 M24 = ~M24;  // 20 unit period
    end

    // Pixel value from plane bits, column mirrored as 7 - n
    function automatic logic [3:0] decodePixel(input logic [31:0] word, input int column,
                                               input logic flip);
        int col;
        logic [3:0] pix;
        col = flip ? (`TILE_WIDTH - 1 - column) : column;
        for (int p = 0; p < 4; p++) begin
            pix[p] = word[8 * p + col];  // Plane p is byte p
        end
        return pix;
    endfunction

    // Layer color word, pixel at the bottom and COL nibbles swapped above it
    function automatic logic [11:0] mapColor(input logic [7:0] attr, input logic [3:0] pix);
        logic [11:0] color;
        color[3:0]  = pix;
        color[7:4]  = attr[7:4];   // High nibble stays in place
        color[11:8] = attr[3:0];   // Low nibble goes on top
        return color;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        if (got !== expected) begin
            $display("Fail at %0t: %s is %0h, expected %0h", $time, name, got, expected);
            $display("test failed");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    task automatic reportTimeout(input string what);
        $display("Timed out waiting for %s", what);
        $display("test failed");
        $fatal(1, "Stopped on timeout");
    endtask

    // Wait for the next falling edge of NHBK, sampled on M24
    task automatic waitBlanking();
        int cycles;
        cycles = 0;
        while (NHBK !== 1'b1) begin
            @(posedge M24);
            cycles++;
            if (cycles > 2 * LineCycles) reportTimeout("NHBK to rise");
        end
        cycles = 0;
        while (NHBK !== 1'b0) begin
            @(posedge M24);
            cycles++;
            if (cycles > 2 * LineCycles) reportTimeout("NHBK to fall");
        end
    endtask

    // New tile data, flip write and one readback, all inside blanking
    task automatic applyLine(input int line);
        logic [1:0] addr;
        rnd = $random(seed);
        VC <= rnd;
        expVc = rnd;
        rnd = $random(seed);
        COL <= rnd[7:0];
        expCol = rnd[7:0];
        zaH <= rnd[10:8];
        expZa = rnd[10:8];
        busWrite <= 1'b1;
        busDataIn <= {rnd[15:10], line[1:0]};  // Cycles through all four flip modes
        expFlipAll = line[0];
        expFlipAttrEn = line[1];
        armed = 1'b1;
        @(posedge M24);
        addr = $random(seed);
        busWrite <= 1'b0;
        busRead <= 1'b1;
        busAddr <= addr;
        @(posedge M24);
        busRead <= 1'b0;
        @(negedge M24);
        checkValue("busOutEn", busOutEn, 1);
        checkValue("busDataOut", busDataOut, expVc[8 * addr +: 8]);
        @(negedge M24);
        checkValue("busOutEn", busOutEn, 0);  // Single cycle only
    endtask

    task automatic comparePixels(input int column);
        logic flip;
        logic [3:0] pix;
        flip = expFlipAll ^ (expFlipAttrEn & expCol[0]);
        pix = decodePixel(expVc, column % `TILE_WIDTH, flip);
        checkValue("DFI", DFI, mapColor(expCol, pix) & 12'h0ff);
        checkValue("NFIC", NFIC, pix != 4'd0);
        pix = decodePixel(expVc, expZa, flip);  // Layer A column from zaH
        checkValue("DSA", DSA, mapColor(expCol, pix));
        checkValue("NSAC", NSAC, pix != 4'd0);
        pixelChecks++;
    endtask

    // M12 toggles on every M24 cycle once out of reset
    always @(negedge M24) begin
        if (rstN && m12Valid) checkValue("M12", M12, !lastM12);
        lastM12 = M12;
        m12Valid = rstN;
    end

    // Raster and pixel checker, outputs are stable at every M6 rise
    always @(posedge M6) begin
        if (rstN) begin
            checkValue("NCSY", NCSY, NHSY & NVSY);
            hRises++;
            if (NHBK) visRises++;
            if (prevNhsy && !NHSY) begin
                if (seenHFall) begin
                    checkValue("pixels per line", hRises, `H_TOTAL);
                    checkValue("visible pixels", visRises, `H_VISIBLE);
                end
                seenHFall = 1'b1;
                hRises = 0;
                visRises = 0;
                hFalls++;
            end
            if (prevNvsy && !NVSY) begin
                if (seenVFall) checkValue("lines per frame", hFalls, `V_TOTAL);
                seenVFall = 1'b1;
                hFalls = 0;
                vFalls++;
                vLine = `V_SYNC_START;  // Sync drops at the first pixel of this line
            end else if (NHBK && k == 0) begin
                vLine = (vLine + 1) % `V_TOTAL;
            end
            if (NHBK) begin
                checkValue("busOutEn", busOutEn, 0);
                checkValue("P1H", P1H, (k + `PIXEL_LATENCY) % 2);  // Count leads pixels
                if (seenVFall) begin
                    checkValue("NVBK", NVBK, vLine < `V_VISIBLE);
                    checkValue("NVSY", NVSY,
                               !(vLine >= `V_SYNC_START && vLine < `V_SYNC_END));
                end
                if (armed) comparePixels(k);
                k++;
            end else begin
                k = 0;  // Restart count for next line
            end
            prevNhsy = NHSY;
            prevNvsy = NVSY;
        end
    end

    initial begin
        seed = 54;
        rstN = 1'b0;
        VC = '0;
        COL = '0;
        zaH = '0;
        busAddr = '0;
        busRead = 1'b0;
        busWrite = 1'b0;
        busDataIn = '0;
        {k, hRises, visRises, hFalls, vFalls, lineNo, pixelChecks, vLine} = '0;
        {armed, seenHFall, seenVFall, lastM12, m12Valid} = '0;
        {prevNhsy, prevNvsy} = 2'b11;
        {expVc, expCol, expZa, expFlipAll, expFlipAttrEn} = '0;
        repeat (10) @(posedge M24);
        checkValue("NHSY", NHSY, 1);
        checkValue("NVSY", NVSY, 1);
        checkValue("NCSY", NCSY, 1);
        checkValue("busOutEn", busOutEn, 0);
        checkValue("DSA", DSA, 0);
        checkValue("DFI", DFI, 0);
        rstN <= 1'b1;
        while (vFalls < 2) begin  // Two NVSY falls cover a full frame
            waitBlanking();
            applyLine(lineNo);
            lineNo++;
            if (lineNo > MaxLines) reportTimeout("two NVSY falls");
        end
        if (pixelChecks == 0) begin
            $display("No pixel was compared during the run");
            $display("test failed");
            $fatal(1, "No pixel checks");
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

`default_nettype wire
